//--- files.f
spi_pkg.sv
spi_crc8.sv
spi_slave.sv
spi_reg_bank.sv
spi_link_top.sv
spi_link_assertions.sv
tb_spi_link.sv

//--- run_sim.sh
#!/bin/sh
# Builds the SPI link testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_spi_link \
  -f files.f -o Vtb_spi_link
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vtb_spi_link > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "tests failed" "$log"; then
  echo "FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
if grep -q "all tests passed" "$log"; then
  echo "PASS"
  exit 0
fi
echo "simulation ended without a result"
exit 1

//--- spi_crc8.sv
`timescale 1ns/10ps

// serial CRC over the MOSI bit stream, one bit per strobe, MSB of each byte first.
module spi_crc8 import spi_pkg::*; #(
  parameter logic [crc_w-1:0] crc_poly = 8'h07,
  parameter logic [crc_w-1:0] crc_init = 8'h00
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_idle,
  input  logic             bit_strobe,
  input  logic             mosi_bit,
  output logic [crc_w-1:0] crc_rx
);

  logic             feedback;
  logic [crc_w-1:0] crc_next;

  assign feedback = mosi_bit ^ crc_rx[crc_w-1]; // incoming bit meets the top bit.

  always_comb begin
    crc_next = {crc_rx[crc_w-2:0], 1'b0};
    if (feedback) begin
      crc_next = crc_next ^ crc_poly;
    end
  end

  // the CRC restarts at every frame boundary.
  always_ff @(posedge clk) begin
    if (reset || frame_idle) begin
      crc_rx <= crc_init;
    end else if (bit_strobe) begin
      crc_rx <= crc_next;
    end
  end

endmodule

//--- spi_link_assertions.sv
`timescale 1ns/10ps

// protocol properties of the SPI slave, attached to every spi_slave instance.
module spi_link_assertions (
  input logic clk,
  input logic reset,
  input logic frame_idle,
  input logic rx_valid,
  input logic tx_load,
  input logic spi_miso
);

  // ======================================================================
  // byte boundary strobes
  // ======================================================================

  // a receive boundary and a transmit load sit half an SPI period apart.
  rx_load_apart: assert property (@(posedge clk) disable iff (reset)
    !(rx_valid && tx_load))
    else $error("rx_valid and tx_load were high in the same cycle");

  rx_only_in_frame: assert property (@(posedge clk) disable iff (reset)
    frame_idle |-> !rx_valid)
    else $error("rx_valid was high while the slave select was high");

  // ======================================================================
  // idle line
  // ======================================================================

  miso_low_when_idle: assert property (@(posedge clk) disable iff (reset)
    frame_idle |-> !spi_miso)
    else $error("spi_miso was driven high outside a frame");

endmodule

//--- spi_link_top.sv
`timescale 1ns/10ps

module spi_link_top import spi_pkg::*; #(
  parameter logic [crc_w-1:0] crc_poly = 8'h07,
  parameter logic [crc_w-1:0] crc_init = 8'h00
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              ena,
  input  logic              spi_clk,
  input  logic              spi_ss,
  input  logic              spi_mosi,
  output logic              spi_miso,
  output logic              rx_valid,
  output logic [byte_w-1:0] rx_byte,
  output logic [crc_w-1:0]  crc_rx
);

  logic              bit_strobe;
  logic              mosi_bit;
  logic              frame_idle;
  logic              tx_load;
  logic [byte_w-1:0] tx_byte;

  spi_slave u_spi_slave (
    .clk        (clk),
    .reset      (reset),
    .ena        (ena),
    .spi_clk    (spi_clk),
    .spi_ss     (spi_ss),
    .spi_mosi   (spi_mosi),
    .tx_byte    (tx_byte),
    .spi_miso   (spi_miso),
    .bit_strobe (bit_strobe),
    .mosi_bit   (mosi_bit),
    .frame_idle (frame_idle),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .tx_load    (tx_load)
  );

  // the CRC sees the raw bit stream, not the assembled bytes.
  spi_crc8 #(
    .crc_poly (crc_poly),
    .crc_init (crc_init)
  ) u_spi_crc8 (
    .clk        (clk),
    .reset      (reset),
    .frame_idle (frame_idle),
    .bit_strobe (bit_strobe),
    .mosi_bit   (mosi_bit),
    .crc_rx     (crc_rx)
  );

  spi_reg_bank u_spi_reg_bank (
    .clk        (clk),
    .reset      (reset),
    .frame_idle (frame_idle),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .tx_load    (tx_load),
    .tx_byte    (tx_byte)
  );

endmodule

//--- spi_pkg.sv
package spi_pkg;

  // ======================================================================
  // data path geometry
  // ======================================================================

  // every SPI transfer unit and every register is one byte wide.
  localparam int byte_w = 8;

  // the register file is addressed by the low nibble of the command byte.
  localparam int addr_w = 4;
  localparam int reg_count = 1 << addr_w; // sixteen registers.

  // ======================================================================
  // command byte and CRC layout
  // ======================================================================

  // a set write flag makes the rest of the frame a write burst.
  localparam int cmd_write_bit = 7;

  // the receive CRC is one byte wide.
  localparam int crc_w = 8;

endpackage

//--- spi_reg_bank.sv
`timescale 1ns/10ps

module spi_reg_bank import spi_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              frame_idle,
  input  logic              rx_valid,
  input  logic [byte_w-1:0] rx_byte,
  input  logic              tx_load,
  output logic [byte_w-1:0] tx_byte
);

  logic [byte_w-1:0] regs [reg_count];
  logic              cmd_seen; // the command byte of this frame has arrived.
  logic              is_write;
  logic [addr_w-1:0] addr;
  logic [addr_w-1:0] addr_next;
  logic              cmd_byte;
  logic              data_write;
  logic              read_step;
  logic              cmd_write;
  logic [addr_w-1:0] cmd_addr;

  // ======================================================================
  // frame decoding
  // ======================================================================

  assign cmd_write = rx_byte[cmd_write_bit];
  assign cmd_addr = rx_byte[addr_w-1:0];
  assign addr_next = addr + 1'b1; // wraps from the last register to the first.

  assign cmd_byte = rx_valid & ~cmd_seen;
  assign data_write = rx_valid & cmd_seen & is_write;
  assign read_step = tx_load & cmd_seen & ~is_write;

  always_ff @(posedge clk) begin
    if (reset || frame_idle) begin
      cmd_seen <= 1'b0;
      is_write <= 1'b0;
      addr <= '0;
    end else if (cmd_byte) begin
      cmd_seen <= 1'b1;
      is_write <= cmd_write;
      addr <= cmd_addr;
    end else if (data_write || read_step) begin
      addr <= addr_next;
    end
  end

  // ======================================================================
  // register file
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (data_write && !frame_idle) begin
      regs[addr] <= rx_byte;
    end
  end

  // ======================================================================
  // transmit byte
  // ======================================================================

  // tx_byte looks one address ahead so that it is ready one cycle after
  // the strobe that moves the address.
  always_ff @(posedge clk) begin
    if (reset || frame_idle) begin
      tx_byte <= '0;
    end else if (cmd_byte) begin
      tx_byte <= cmd_write ? '0 : regs[cmd_addr]; // write frames send zeros.
    end else if (read_step) begin
      tx_byte <= regs[addr_next];
    end
  end

endmodule

//--- spi_slave.sv
`timescale 1ns/10ps

module spi_slave import spi_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              ena,
  input  logic              spi_clk,
  input  logic              spi_ss,
  input  logic              spi_mosi,
  input  logic [byte_w-1:0] tx_byte,
  output logic              spi_miso,
  output logic              bit_strobe,
  output logic              mosi_bit,
  output logic              frame_idle,
  output logic              rx_valid,
  output logic [byte_w-1:0] rx_byte,
  output logic              tx_load
);

  localparam int cnt_w = $clog2(byte_w);

  logic [2:0]        clk_sync; // two synchronizer stages plus the edge-detect copy.
  logic [1:0]        ss_sync;
  logic [1:0]        mosi_sync;
  logic              clk_rise;
  logic              clk_fall;
  logic              rise_strobe;
  logic [cnt_w-1:0]  rx_cnt;
  logic [cnt_w-1:0]  tx_cnt;
  logic [byte_w-1:0] rx_shift;
  logic [byte_w-1:0] tx_shift;

  // ======================================================================
  // input synchronizers and edge detection
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      clk_sync <= '0;
      ss_sync <= '1; // the link starts out idle.
    end else begin
      clk_sync <= {clk_sync[1:0], spi_clk};
      ss_sync <= {ss_sync[0], spi_ss};
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[0], spi_mosi};
    mosi_bit <= mosi_sync[1]; // stays aligned with bit_strobe.
  end

  assign frame_idle = ss_sync[1];
  assign clk_rise = clk_sync[1] & ~clk_sync[2];
  assign clk_fall = ~clk_sync[1] & clk_sync[2];

  // edges only count while enabled and inside a frame.
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_strobe <= 1'b0;
      rise_strobe <= 1'b0;
    end else begin
      bit_strobe <= ena & clk_fall & ~frame_idle;
      rise_strobe <= ena & clk_rise & ~frame_idle;
    end
  end

  // ======================================================================
  // receive side
  // ======================================================================

  always_ff @(posedge clk) begin
    if (reset || frame_idle) begin
      rx_cnt <= '0;
      rx_shift <= '0; // a partial byte is dropped here.
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= bit_strobe && (rx_cnt == cnt_w'(byte_w - 1));
      if (bit_strobe) begin
        rx_shift <= {rx_shift[byte_w-2:0], mosi_bit};
        rx_cnt <= rx_cnt + 1'b1; // wraps to zero after the eighth bit.
      end
    end
  end

  assign rx_byte = rx_shift;

  // ======================================================================
  // transmit side
  // ======================================================================

  assign tx_load = rise_strobe & (tx_cnt == '0);

  always_ff @(posedge clk) begin
    if (reset || frame_idle) begin
      tx_cnt <= '0;
    end else if (rise_strobe) begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  // the shifter clears on the first select stage, one cycle ahead of frame_idle.
  always_ff @(posedge clk) begin
    if (reset || ss_sync[0]) begin
      tx_shift <= '0;
    end else if (rise_strobe) begin
      tx_shift <= tx_load ? tx_byte : {tx_shift[byte_w-2:0], 1'b0};
    end
  end

  assign spi_miso = tx_shift[byte_w-1]; // already low by the time frame_idle rises.

endmodule

//--- tb_spi_link.sv
`timescale 1ns/10ps

module tb_spi_link;

  localparam logic [7:0] crc_poly = 8'h07;
  localparam logic [7:0] crc_init = 8'h00;
  localparam int half_period = 8; // SPI half-period in clk cycles.
  localparam int total_bytes = 64; // all bytes of all frames in the run.
  localparam int timeout_cycles = total_bytes * 16 * half_period + 1000;

  typedef logic [7:0] byte_q_t [$];

  logic       clk = 1'b0;
  logic       reset;
  logic       ena;
  logic       spi_clk;
  logic       spi_ss;
  logic       spi_mosi;
  logic       spi_miso;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic [7:0] crc_rx;

  integer     seed = 22106;
  logic [7:0] model [16]; // expected register contents.
  byte_q_t    exp_rx; // MOSI bytes still to show up on rx_byte.
  byte_q_t    miso_bytes; // what the master read in the last frame.
  byte_q_t    q;
  logic [3:0] a;
  logic [7:0] d;

  spi_link_top #(
    .crc_poly (crc_poly),
    .crc_init (crc_init)
  ) u_spi_link_top (
    .clk      (clk),
    .reset    (reset),
    .ena      (ena),
    .spi_clk  (spi_clk),
    .spi_ss   (spi_ss),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso),
    .rx_valid (rx_valid),
    .rx_byte  (rx_byte),
    .crc_rx   (crc_rx)
  );

  bind spi_slave spi_link_assertions u_spi_link_assertions (
    .clk        (clk),
    .reset      (reset),
    .frame_idle (frame_idle),
    .rx_valid   (rx_valid),
    .tx_load    (tx_load),
    .spi_miso   (spi_miso)
  );

  always #10 clk = ~clk;

  // ======================================================================
  // reference model and checking
  // ======================================================================

  function automatic logic [7:0] ref_crc8(input byte_q_t data);
    logic [7:0] crc;
    logic       fb;
    crc = crc_init;
    foreach (data[k]) begin
      for (int b = 7; b >= 0; b--) begin
        fb = data[k][b] ^ crc[7];
        crc = {crc[6:0], 1'b0};
        if (fb) begin
          crc = crc ^ crc_poly;
        end
      end
    end
    return crc;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("Mismatch in %s: expected %02h, actual %02h",
                               name, expected, actual));
    end
  endtask

  // every received byte must be the next one the master sent.
  always @(negedge clk) begin
    if (!reset && rx_valid) begin
      if (exp_rx.size() == 0) begin
        report_failure("rx_valid pulsed although no byte was being sent");
      end else begin
        check("rx_byte", exp_rx.pop_front(), rx_byte);
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    report_failure("timeout: the test sequence did not finish in time");
  end

  // ======================================================================
  // SPI master
  // ======================================================================

  // starts and ends on a clk edge with spi_clk low.
  task automatic shift_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
    rx = 8'h00;
    for (int i = 7; i >= 8 - nbits; i--) begin
      spi_clk <= 1'b1;
      spi_mosi <= tx[i];
      repeat (half_period - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = spi_miso;
      @(posedge clk);
      spi_clk <= 1'b0;
      repeat (half_period) @(posedge clk);
    end
  endtask

  task automatic spi_frame(input byte_q_t mosi_bytes);
    logic [7:0] rx;
    miso_bytes.delete();
    spi_ss <= 1'b0;
    repeat (half_period) @(posedge clk);
    foreach (mosi_bytes[k]) begin
      if (ena) begin
        exp_rx.push_back(mosi_bytes[k]);
      end
      shift_byte(mosi_bytes[k], 8, rx);
      miso_bytes.push_back(rx);
    end
    repeat (half_period) @(posedge clk);
    if (ena) begin
      check("crc_rx", ref_crc8(mosi_bytes), crc_rx);
    end
    spi_ss <= 1'b1;
    repeat (2 * half_period) @(posedge clk);
  endtask

  // a full command byte, then only part of a data byte.
  task automatic spi_abort(input logic [7:0] cmd, input logic [7:0] data, input int nbits);
    logic [7:0] rx;
    spi_ss <= 1'b0;
    repeat (half_period) @(posedge clk);
    exp_rx.push_back(cmd);
    shift_byte(cmd, 8, rx);
    shift_byte(data, nbits, rx);
    repeat (half_period) @(posedge clk);
    spi_ss <= 1'b1;
    repeat (2 * half_period) @(posedge clk);
  endtask

  task automatic read_all_and_compare(input string name);
    q.delete();
    q.push_back(8'h00);
    for (int i = 0; i < 16; i++) begin
      q.push_back(8'h00);
    end
    spi_frame(q);
    check({name, " command slot"}, 8'h00, miso_bytes[0]);
    for (int i = 0; i < 16; i++) begin
      check(name, model[i], miso_bytes[i+1]);
    end
  endtask

  // ======================================================================
  // test sequence
  // ======================================================================

  initial begin
    reset <= 1'b1;
    ena <= 1'b1;
    spi_clk <= 1'b0;
    spi_ss <= 1'b1;
    spi_mosi <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      model[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check("reset spi_miso", 8'h00, {7'b0, spi_miso});
    check("reset rx_valid", 8'h00, {7'b0, rx_valid});
    check("reset crc_rx", 8'h00, crc_rx);
    @(posedge clk);

    // single write, then read it back.
    d = rand_byte();
    a = d[3:0];
    d = rand_byte();
    model[a] = d;
    q.delete();
    q.push_back({4'h8, a});
    q.push_back(d);
    spi_frame(q);
    foreach (miso_bytes[k]) begin
      check("write frame miso", 8'h00, miso_bytes[k]);
    end
    q.delete();
    q.push_back({4'h0, a});
    q.push_back(8'h00);
    spi_frame(q);
    check("single read", model[a], miso_bytes[1]);

    // burst write that wraps past the last register.
    a = 4'd12;
    q.delete();
    q.push_back(8'h8c);
    for (int i = 0; i < 20; i++) begin
      d = rand_byte();
      q.push_back(d);
      model[a] = d;
      a = a + 4'd1;
    end
    spi_frame(q);
    read_all_and_compare("burst read");

    // partial byte, then a disabled write frame; neither may change a register.
    spi_abort(8'h83, 8'ha5, 5);
    @(posedge clk);
    ena <= 1'b0;
    @(posedge clk);
    q.delete();
    q.push_back(8'h80);
    q.push_back(rand_byte());
    q.push_back(rand_byte());
    spi_frame(q);
    ena <= 1'b1;
    @(posedge clk);
    read_all_and_compare("read after abort");

    repeat (4) @(posedge clk);
    if (exp_rx.size() != 0) begin
      report_failure("some MOSI bytes never appeared on rx_byte");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule
